// File: Bender.yml
package:
  name: aes_decipher_core

sources:
  # RTL, package first
  - files:
      - design/aes_dec_pkg.sv
      - design/aes_inv_sbox.sv
      - design/aes_inv_mixcolumns.sv
      - design/aes_dec_ctrl.sv
      - design/aes_dec_datapath.sv
      - design/aes_decipher_core.sv

  # Testbench with the reference model header
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_aes_decipher_core.sv

// File: aes_decipher_core.f
+incdir+include
design/aes_dec_pkg.sv
design/aes_inv_sbox.sv
design/aes_inv_mixcolumns.sv
design/aes_dec_ctrl.sv
design/aes_dec_datapath.sv
design/aes_decipher_core.sv
sim/tb_aes_decipher_core.sv

// File: design/aes_dec_ctrl.sv
//--------------------------------------------------------------------
// Decipher controller with the FSM, word counter and round counter
// Tells the datapath which update to apply and which word to substitute,
// and publishes the round index for the external key store
//--------------------------------------------------------------------
`timescale 1ns/10ps

module aes_dec_ctrl (
  input  logic                        iClk,
  input  logic                        rst,
  input  logic                        next,
  input  logic                        keylen,
  output aes_dec_pkg::round_t         round,
  output logic                        ready,
  output aes_dec_pkg::update_kind_t   update,
  output aes_dec_pkg::sword_t         sword
);

  import aes_dec_pkg::*;

  //------------------------------------------------------------------
  // Registers
  //------------------------------------------------------------------

  dec_state_t state_reg;
  sword_t     sword_ctr;
  round_t     round_ctr;
  logic       ready_reg;

  // Rounds still left after the current one
  logic       round_nz;

  assign round_nz = (round_ctr != '0);

  assign round = round_ctr;
  assign sword = sword_ctr;
  assign ready = ready_reg;

  //------------------------------------------------------------------
  // Update kind decode
  //------------------------------------------------------------------

  always_comb begin
    update = UPD_NONE;
    case (state_reg)
      DEC_INIT: begin
        // AddRoundKey on the input block, then InvShiftRows
        update = UPD_INIT;
      end
      DEC_SUBBYTES: begin
        update = UPD_SBOX;
      end
      DEC_ROUND_END: begin
        // Counter already stepped, so zero means last key
        if (round_nz) begin
          update = UPD_MAIN;
        end else begin
          update = UPD_FINAL;
        end
      end
      default: begin
        update = UPD_NONE;
      end
    endcase
  end

  //------------------------------------------------------------------
  // FSM, counters and ready
  //------------------------------------------------------------------

  always_ff @(posedge iClk) begin
    if (rst) begin
      state_reg <= DEC_IDLE;
      sword_ctr <= '0;
      round_ctr <= '0;
      ready_reg <= 1'b1;
    end else begin
      case (state_reg)
        DEC_IDLE: begin
          // Key length is only looked at here
          if (next) begin
            round_ctr <= keylen ? AES256_ROUNDS : AES128_ROUNDS;
            ready_reg <= 1'b0;
            state_reg <= DEC_INIT;
          end
        end
        DEC_INIT: begin
          sword_ctr <= '0;
          state_reg <= DEC_SUBBYTES;
        end
        DEC_SUBBYTES: begin
          sword_ctr <= sword_ctr + sword_t'(1);
          // Last word of the round, step to the next key index
          if (sword_ctr == sword_t'(WORDS_PER_BLOCK - 1)) begin
            round_ctr <= round_ctr - round_t'(1);
            state_reg <= DEC_ROUND_END;
          end
        end
        DEC_ROUND_END: begin
          sword_ctr <= '0;
          if (round_nz) begin
            state_reg <= DEC_SUBBYTES;
          end else begin
            // Result is in the datapath after this edge
            ready_reg <= 1'b1;
            state_reg <= DEC_IDLE;
          end
        end
        default: begin
          state_reg <= DEC_IDLE;
        end
      endcase
    end
  end

endmodule

// File: design/aes_dec_datapath.sv
//--------------------------------------------------------------------
// Block state register and round logic of the decipher core
// Applies AddRoundKey, InvShiftRows, InvMixColumns and word-wise
// InvSubBytes as selected by the controller
//--------------------------------------------------------------------
`timescale 1ns/10ps

module aes_dec_datapath (
  input  logic                        iClk,
  input  logic                        rst,
  input  aes_dec_pkg::update_kind_t   update,
  input  aes_dec_pkg::sword_t         sword,
  input  aes_dec_pkg::block_t         block,
  input  aes_dec_pkg::block_t         round_key,
  output aes_dec_pkg::block_t         new_block
);

  import aes_dec_pkg::*;

  // Byte i sits at bits 127-8i, column i/4, row i%4
  function automatic block_t inv_shift_rows(input block_t in_blk);
    block_t out_blk;
    int     src_col;
    out_blk = '0;
    for (int col = 0; col < 4; col++) begin
      for (int row = 0; row < 4; row++) begin
        // Row r rotates right by r columns
        src_col = (col - row + 4) % 4;
        out_blk[127 - 8*(4*col + row) -: 8] = in_blk[127 - 8*(4*src_col + row) -: 8];
      end
    end
    return out_blk;
  endfunction

  //------------------------------------------------------------------
  // Signals
  //------------------------------------------------------------------

  word_t                      state_words [WORDS_PER_BLOCK];
  logic [WORDS_PER_BLOCK-1:0] word_we;
  logic                       full_write;
  block_t                     state_blk;
  block_t                     addkey_blk;
  block_t                     mix_blk;
  block_t                     block_next;
  word_t                      sbox_in;
  word_t                      sbox_out;

  assign state_blk = {state_words[0], state_words[1], state_words[2], state_words[3]};
  assign new_block = state_blk;

  // Input block only enters on the init update
  assign addkey_blk = ((update == UPD_INIT) ? block : state_blk) ^ round_key;

  // One word per cycle through the S-box
  assign sbox_in = state_words[sword];

  aes_inv_sbox inv_sbox_inst (
    .in_word  (sbox_in),
    .out_word (sbox_out)
  );

  aes_inv_mixcolumns inv_mixcolumns_inst (
    .in_block  (addkey_blk),
    .out_block (mix_blk)
  );

  //------------------------------------------------------------------
  // Next state and write enables
  //------------------------------------------------------------------

  always_comb begin
    case (update)
      UPD_INIT:  block_next = inv_shift_rows(addkey_blk);
      UPD_SBOX:  block_next = {WORDS_PER_BLOCK{sbox_out}};
      UPD_MAIN:  block_next = inv_shift_rows(mix_blk);
      UPD_FINAL: block_next = addkey_blk;
      default:   block_next = state_blk;
    endcase
  end

  always_comb begin
    full_write = (update == UPD_INIT) || (update == UPD_MAIN) || (update == UPD_FINAL);
    for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
      // S-box update only touches the selected word
      word_we[w] = full_write || ((update == UPD_SBOX) && (sword == sword_t'(w)));
    end
  end

  // Word 0 is the most significant column
  for (genvar i = 0; i < WORDS_PER_BLOCK; i++) begin : g_word
    always_ff @(posedge iClk) begin
      if (rst) begin
        state_words[i] <= '0;
      end else if (word_we[i]) begin
        state_words[i] <= block_next[127 - 32*i -: 32];
      end
    end
  end

endmodule

// File: design/aes_dec_pkg.sv
//--------------------------------------------------------------------
// Shared widths, round counts and enums for the AES decipher core
// Imported by every RTL module of the round engine
//--------------------------------------------------------------------

package aes_dec_pkg;

  //------------------------------------------------------------------
  // Data widths
  //------------------------------------------------------------------

  // Full cipher state, four columns of four bytes
  typedef logic [127:0] block_t;
  // One column of the state
  typedef logic [31:0]  word_t;
  // One state byte
  typedef logic [7:0]   byte_t;
  // Round index towards the key store
  typedef logic [3:0]   round_t;
  // Index of the word in the S-box this cycle
  typedef logic [1:0]   sword_t;

  //------------------------------------------------------------------
  // Constants
  //------------------------------------------------------------------

  localparam round_t AES128_ROUNDS   = 4'd10;
  localparam round_t AES256_ROUNDS   = 4'd14;
  localparam int     WORDS_PER_BLOCK = 4;

  //------------------------------------------------------------------
  // Control encodings
  //------------------------------------------------------------------

  // Decipher FSM
  typedef enum logic [1:0] {
    DEC_IDLE      = 2'd0,
    DEC_INIT      = 2'd1,
    DEC_SUBBYTES  = 2'd2,
    DEC_ROUND_END = 2'd3
  } dec_state_t;

  // Which state update the datapath applies this cycle
  typedef enum logic [2:0] {
    UPD_NONE  = 3'd0,
    UPD_INIT  = 3'd1,
    UPD_SBOX  = 3'd2,
    UPD_MAIN  = 3'd3,
    UPD_FINAL = 3'd4
  } update_kind_t;

endpackage

// File: design/aes_decipher_core.sv
//--------------------------------------------------------------------
// AES inverse cipher round engine, AES-128 and AES-256
// Pulse next while ready is high, serve round_key for the index on
// round, and read new_block once ready returns high
//--------------------------------------------------------------------
`timescale 1ns/10ps

module aes_decipher_core (
  input  logic                iClk,
  input  logic                rst,
  input  logic                next,
  input  logic                keylen,
  output aes_dec_pkg::round_t round,
  input  aes_dec_pkg::block_t round_key,
  input  aes_dec_pkg::block_t block,
  output aes_dec_pkg::block_t new_block,
  output logic                ready
);

  import aes_dec_pkg::*;

  // Controller to datapath
  update_kind_t update;
  sword_t       sword;

  //------------------------------------------------------------------
  // Control
  //------------------------------------------------------------------

  aes_dec_ctrl aes_dec_ctrl_inst (
    .iClk   (iClk),
    .rst    (rst),
    .next   (next),
    .keylen (keylen),
    .round  (round),
    .ready  (ready),
    .update (update),
    .sword  (sword)
  );

  //------------------------------------------------------------------
  // State and round logic
  //------------------------------------------------------------------

  aes_dec_datapath aes_dec_datapath_inst (
    .iClk      (iClk),
    .rst       (rst),
    .update    (update),
    .sword     (sword),
    .block     (block),
    .round_key (round_key),
    .new_block (new_block)
  );

endmodule

// File: design/aes_inv_mixcolumns.sv
//--------------------------------------------------------------------
// Inverse MixColumns over a full 128-bit state
// Each column is multiplied by the fixed matrix {0e 0b 0d 09} in GF(2^8)
//--------------------------------------------------------------------
`timescale 1ns/10ps

module aes_inv_mixcolumns (
  input  aes_dec_pkg::block_t in_block,
  output aes_dec_pkg::block_t out_block
);

  import aes_dec_pkg::*;

  //------------------------------------------------------------------
  // Field multiples
  //------------------------------------------------------------------

  // Multiply by x, reduced by 0x11b
  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic byte_t gm09(input byte_t b);
    return xtime(xtime(xtime(b))) ^ b;
  endfunction

  function automatic byte_t gm11(input byte_t b);
    return xtime(xtime(xtime(b))) ^ xtime(b) ^ b;
  endfunction

  function automatic byte_t gm13(input byte_t b);
    return xtime(xtime(xtime(b))) ^ xtime(xtime(b)) ^ b;
  endfunction

  function automatic byte_t gm14(input byte_t b);
    return xtime(xtime(xtime(b))) ^ xtime(xtime(b)) ^ xtime(b);
  endfunction

  // Row 0 is the top byte of the column
  function automatic word_t inv_mix_word(input word_t w);
    byte_t b0, b1, b2, b3;
    b0 = w[31:24];
    b1 = w[23:16];
    b2 = w[15:8];
    b3 = w[7:0];
    return {gm14(b0) ^ gm11(b1) ^ gm13(b2) ^ gm09(b3),
            gm09(b0) ^ gm14(b1) ^ gm11(b2) ^ gm13(b3),
            gm13(b0) ^ gm09(b1) ^ gm14(b2) ^ gm11(b3),
            gm11(b0) ^ gm13(b1) ^ gm09(b2) ^ gm14(b3)};
  endfunction

  // Columns are independent
  for (genvar col = 0; col < WORDS_PER_BLOCK; col++) begin : g_col
    assign out_block[127 - 32*col -: 32] = inv_mix_word(in_block[127 - 32*col -: 32]);
  end

endmodule

// File: design/aes_inv_sbox.sv
//--------------------------------------------------------------------
// Inverse AES S-box on one 32-bit word
// Four parallel lookups into a constant 256-entry table
//--------------------------------------------------------------------
`timescale 1ns/10ps

module aes_inv_sbox (
  input  aes_dec_pkg::word_t in_word,
  output aes_dec_pkg::word_t out_word
);

  import aes_dec_pkg::*;

  //------------------------------------------------------------------
  // Table
  //------------------------------------------------------------------

  // Entry 0 in the top byte, one row of 16 entries per line
  localparam logic [2047:0] INV_SBOX = {
    128'h52096ad53036a538bf40a39e81f3d7fb,
    128'h7ce339829b2fff87348e4344c4dee9cb,
    128'h547b9432a6c2233dee4c950b42fac34e,
    128'h082ea16628d924b2765ba2496d8bd125,
    128'h72f8f66486689816d4a45ccc5d65b692,
    128'h6c704850fdedb9da5e154657a78d9d84,
    128'h90d8ab008cbcd30af7e45805b8b34506,
    128'hd02c1e8fca3f0f02c1afbd0301138a6b,
    128'h3a9111414f67dcea97f2cfcef0b4e673,
    128'h96ac7422e7ad3585e2f937e81c75df6e,
    128'h47f11a711d29c5896fb7620eaa18be1b,
    128'hfc563e4bc6d279209adbc0fe78cd5af4,
    128'h1fdda8338807c731b11210592780ec5f,
    128'h60517fa919b54a0d2de57a9f93c99cef,
    128'ha0e03b4dae2af5b0c8ebbb3c83539961,
    128'h172b047eba77d626e169146355210c7d
  };

  //------------------------------------------------------------------
  // Lookup
  //------------------------------------------------------------------

  function automatic byte_t inv_sub_byte(input byte_t b);
    int idx;
    idx = int'(b);
    return INV_SBOX[2047 - 8*idx -: 8];
  endfunction

  // Same table on every byte lane
  for (genvar lane = 0; lane < 4; lane++) begin : g_lane
    assign out_word[8*lane +: 8] = inv_sub_byte(in_word[8*lane +: 8]);
  end

endmodule

// File: include/aes_dec_model.svh
//--------------------------------------------------------------------
// Reference model functions for the decipher core testbench
// Included inside the testbench module and works on plain vectors
//--------------------------------------------------------------------
`ifndef AES_DEC_MODEL_SVH
`define AES_DEC_MODEL_SVH

// Xorshift32 step on a non-zero state
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// GF(2^8) product modulo 0x11b
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] aa;
  p  = 8'h00;
  aa = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      p = p ^ aa;
    end
    aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// Field inverse as a^254 which also maps zero to zero
function automatic logic [7:0] gf_inv(input logic [7:0] a);
  logic [7:0] r;
  r = 8'h01;
  for (int i = 0; i < 254; i++) begin
    r = gf_mul(r, a);
  end
  return (a == 8'h00) ? 8'h00 : r;
endfunction

// Undo the affine map, then invert in the field
function automatic logic [7:0] inv_sbox_byte(input logic [7:0] y);
  logic [7:0] x;
  x = {y[6:0], y[7]} ^ {y[4:0], y[7:5]} ^ {y[1:0], y[7:2]} ^ 8'h05;
  return gf_inv(x);
endfunction

function automatic logic [127:0] inv_sub_bytes(input logic [127:0] s);
  logic [127:0] r;
  for (int i = 0; i < 16; i++) begin
    r[8*i +: 8] = inv_sbox_byte(s[8*i +: 8]);
  end
  return r;
endfunction

function automatic logic [127:0] inv_shift_rows(input logic [127:0] s);
  logic [127:0] r;
  for (int c = 0; c < 4; c++) begin
    for (int row = 0; row < 4; row++) begin
      r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + 4 - row) % 4) + row) -: 8];
    end
  end
  return r;
endfunction

function automatic logic [127:0] inv_mix_columns(input logic [127:0] s);
  logic [127:0] r;
  logic [7:0]   b [4];
  for (int c = 0; c < 4; c++) begin
    for (int k = 0; k < 4; k++) begin
      b[k] = s[127 - 8*(4*c + k) -: 8];
    end
    for (int k = 0; k < 4; k++) begin
      r[127 - 8*(4*c + k) -: 8] = gf_mul(b[k], 8'h0e) ^
                                  gf_mul(b[(k + 1) % 4], 8'h0b) ^
                                  gf_mul(b[(k + 2) % 4], 8'h0d) ^
                                  gf_mul(b[(k + 3) % 4], 8'h09);
    end
  end
  return r;
endfunction

// Full inverse cipher with keys indexed by round
function automatic logic [127:0] decrypt_block(input logic [127:0] ct,
                                               input logic [127:0] keys [15],
                                               input int nr);
  logic [127:0] s;
  s = inv_shift_rows(ct ^ keys[nr]);
  for (int r = nr - 1; r >= 1; r--) begin
    s = inv_sub_bytes(s) ^ keys[r];
    s = inv_shift_rows(inv_mix_columns(s));
  end
  return inv_sub_bytes(s) ^ keys[0];
endfunction

`endif

// File: sim/tb_aes_decipher_core.sv
//--------------------------------------------------------------------
// Self-checking testbench for the AES decipher core
// Random round keys and ciphertexts from an xorshift generator, each
// result compared with the reference decrypt of the model header
//--------------------------------------------------------------------
`timescale 1ns/10ps

module tb_aes_decipher_core;

  `include "aes_dec_model.svh"

  localparam int TIMEOUT_CYCLES = 200;

  logic         iClk;
  logic         rst;
  logic         next;
  logic         keylen;
  logic [3:0]   round;
  logic [127:0] round_key;
  logic [127:0] block;
  logic [127:0] new_block;
  logic         ready;

  // Round key store indexed 0 to 14
  logic [127:0] keys [15];
  logic [31:0]  rng_state;
  int           error_count;
  int           test_count;
  int           failed_tests;
  bit           timed_out;
  // Latency and output of the last block
  int           latency;
  logic [127:0] result;

  aes_decipher_core aes_decipher_core_inst (
    .iClk      (iClk),
    .rst       (rst),
    .next      (next),
    .keylen    (keylen),
    .round     (round),
    .round_key (round_key),
    .block     (block),
    .new_block (new_block),
    .ready     (ready)
  );

  always #5 iClk = ~iClk;

  // Key store answers the published round index
  always @(posedge iClk) begin
    #1;
    round_key = keys[round];
  end

  //------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [127:0] rand_block();
    logic [127:0] b;
    for (int i = 0; i < 4; i++) begin
      b[32*i +: 32] = rand32();
    end
    return b;
  endfunction

  task automatic fill_keys();
    for (int i = 0; i < 15; i++) begin
      keys[i] = rand_block();
    end
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count > errors_before) begin
      failed_tests++;
      $display("%s: failed", name);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  // Start one block from idle and wait for ready to come back
  task automatic run_block(input logic kl, input logic [127:0] ct,
                           input bit hold_next, input bit disturb);
    logic [31:0] r;
    next   = 1'b1;
    keylen = kl;
    block  = ct;
    @(posedge iClk);
    #1;
    if (!hold_next) begin
      next = 1'b0;
    end
    check_value("ready low after start", 128'(1'b0), 128'(ready));
    latency = 0;
    while (!ready && !timed_out) begin
      @(posedge iClk);
      #1;
      latency++;
      if (latency >= TIMEOUT_CYCLES) begin
        $display("Timeout: ready did not return within %0d cycles", TIMEOUT_CYCLES);
        timed_out = 1'b1;
        error_count++;
      end else if (!ready && disturb) begin
        // Block was taken on the init edge, so everything may move now
        r      = rand32();
        next   = r[0];
        keylen = r[1];
        block  = rand_block();
      end
    end
    next   = hold_next;
    result = new_block;
  endtask

  //------------------------------------------------------------------
  // Tests
  //------------------------------------------------------------------

  task automatic verify_reset();
    int errs;
    errs = error_count;
    check_value("reset ready", 128'(1'b1), 128'(ready));
    check_value("reset round", 128'(0), 128'(round));
    check_value("reset new_block", 128'(0), new_block);
    finish_test("reset_state", errs);
  endtask

  task automatic decrypt_random_blocks(input string name, input logic kl, input int count,
                                       input bit disturb);
    int           errs;
    int           nr;
    logic [127:0] ct;
    if (timed_out) begin
      return;
    end
    errs = error_count;
    nr   = kl ? 14 : 10;
    fill_keys();
    for (int i = 0; i < count && !timed_out; i++) begin
      ct = rand_block();
      run_block(kl, ct, 1'b0, disturb);
      check_value($sformatf("%s block %0d", name, i), decrypt_block(ct, keys, nr), result);
      check_value($sformatf("%s latency %0d", name, i), 128'(1 + 5*nr), 128'(latency));
    end
    finish_test(name, errs);
  endtask

  task automatic stream_back_to_back();
    int           errs;
    int           nr;
    logic [127:0] ct;
    if (timed_out) begin
      return;
    end
    errs = error_count;
    fill_keys();
    // Alternating key lengths with next held high between blocks
    for (int i = 0; i < 6 && !timed_out; i++) begin
      ct = rand_block();
      nr = i[0] ? 14 : 10;
      run_block(i[0], ct, 1'b1, 1'b0);
      check_value($sformatf("back_to_back block %0d", i), decrypt_block(ct, keys, nr),
                  result);
      check_value($sformatf("back_to_back latency %0d", i), 128'(1 + 5*nr), 128'(latency));
    end
    next = 1'b0;
    finish_test("back_to_back", errs);
  endtask

  task automatic hold_result();
    int           errs;
    logic [127:0] ct;
    logic [127:0] held;
    if (timed_out) begin
      return;
    end
    errs = error_count;
    fill_keys();
    ct = rand_block();
    run_block(1'b0, ct, 1'b0, 1'b0);
    check_value("hold result", decrypt_block(ct, keys, 10), result);
    held = new_block;
    for (int i = 0; i < 20; i++) begin
      @(posedge iClk);
      #1;
      check_value("hold new_block", held, new_block);
      check_value("hold ready", 128'(1'b1), 128'(ready));
    end
    finish_test("result_hold", errs);
  endtask

  //------------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------------

  initial begin
    iClk         = 1'b0;
    rst          = 1'b1;
    next         = 1'b0;
    keylen       = 1'b0;
    block        = '0;
    round_key    = '0;
    rng_state    = 32'd7;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    timed_out    = 1'b0;
    for (int i = 0; i < 15; i++) begin
      keys[i] = '0;
    end
    repeat (5) @(posedge iClk);
    #1;
    rst = 1'b0;
    verify_reset();
    decrypt_random_blocks("decrypt_aes128", 1'b0, 20, 1'b0);
    decrypt_random_blocks("decrypt_aes256", 1'b1, 20, 1'b0);
    decrypt_random_blocks("busy_inputs_ignored", 1'b1, 5, 1'b1);
    stream_back_to_back();
    hold_result();
    $display("Tests run: %0d, failed: %0d, errors: %0d", test_count, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
